// File: build.f
rs_pkg.sv
rename_map.sv
station_array.sv
issue_select.sv
reservation_station.sv
tb_clock_gen.sv
tb_reservation_station.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_reservation_station -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1

// File: tb_reservation_station.sv
// random testbench with a cycle model; tags are reused only after retire, run length is fixed
`timescale 1ns/100ps
`default_nettype none

module tb_reservation_station;

   localparam int phase_cycles = 400;
   localparam int num_phases   = 5;
   localparam int num_cycles   = phase_cycles * num_phases;
   localparam int watchdog_ns  = (num_cycles + 3 + 60) * 4;

   logic                 clock;
   logic                 reset;
   rs_pkg::dispatch_t    dispatch;
   rs_pkg::cdb_t         cdb;
   rs_pkg::retire_t      retire;
   rs_pkg::station_vec_t exec_busy;
   rs_pkg::station_vec_t station_free;
   rs_pkg::station_vec_t issue_valid;
   rs_pkg::issue_t       issue_data [rs_pkg::num_stations];

   integer seed = 50449;
   int     error_count = 0;
   string  current_test = "reset_state";

   ////////////////////////////////////////////////////////////////////////////
   // model state
   ////////////////////////////////////////////////////////////////////////////

   // map table and architectural values
   logic             map_pending [32];
   logic             map_ready [32];
   rs_pkg::rob_tag_t map_tag [32];
   rs_pkg::word_t    arch_value [32];

   // per tag: 0 free, 1 in flight, 2 result on cdb
   int               tag_state [8];
   rs_pkg::word_t    tag_result [8];
   rs_pkg::reg_idx_t tag_dest [8];

   // station contents
   rs_pkg::station_vec_t st_busy;
   rs_pkg::fu_class_t    st_class [5];
   rs_pkg::rob_tag_t     st_tag [5];
   rs_pkg::reg_idx_t     st_dest [5];
   rs_pkg::operand_t     st_op [5][2];

   // predicted issue outputs
   rs_pkg::station_vec_t exp_valid;
   rs_pkg::issue_t       exp_data [5];

   tb_clock_gen clock_gen (
      .clock (clock),
      .reset (reset)
   );

   reservation_station dut (
      .clock        (clock),
      .reset        (reset),
      .dispatch     (dispatch),
      .cdb          (cdb),
      .retire       (retire),
      .exec_busy    (exec_busy),
      .station_free (station_free),
      .issue_valid  (issue_valid),
      .issue_data   (issue_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // random tag in the given state, -1 if none
   function automatic int pick_tag(input int state);
      int start;
      int t;
      start = rand_below(8);
      for (int n = 0; n < 8; n++) begin
         t = (start + n) % 8;
         if (tag_state[t] == state) return t;
      end
      return -1;
   endfunction

   // true value for unrenamed or ready sources, junk while pending
   function automatic rs_pkg::word_t source_value(input rs_pkg::reg_idx_t r);
      if (!map_pending[r]) return arch_value[r];
      if (map_ready[r]) return tag_result[map_tag[r]];
      return rs_pkg::word_t'($random(seed));
   endfunction

   function automatic string phase_name(input int phase);
      case (phase)
         0:       return "ready_operands";
         1:       return "wakeup";
         2:       return "back_pressure";
         3:       return "mul_overflow";
         default: return "retire";
      endcase
   endfunction

   task automatic check_value(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("mismatch in %s %s: expected %h actual %h",
                  current_test, what, expected, actual);
         $display("Done: errors found");
         $fatal(1, "stopped at first failing check");
      end
   endtask

   task automatic check_outputs();
      rs_pkg::station_vec_t exp_free;
      exp_free = ~st_busy;
      check_value("station_free", 128'(exp_free), 128'(station_free));
      check_value("issue_valid", 128'(exp_valid), 128'(issue_valid));
      for (int i = 0; i < 5; i++) begin
         if (exp_valid[i]) begin
            check_value($sformatf("issue_data[%0d]", i), 128'(exp_data[i]),
                        128'(issue_data[i]));
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   // phase 0 reads regs 16..31 which are never renamed
   // phase 2 holds units busy, phase 3 floods the multipliers
   task automatic drive_inputs(input int phase);
      int t;
      int src_base;
      int src_span;
      int busy_odds;
      int cdb_odds;
      src_base  = (phase == 0) ? 16 : 0;
      src_span  = (phase == 0) ? 16 : 10;
      busy_odds = (phase == 0) ? 0 : (phase == 2) ? 6 : (phase == 3) ? 4 : 1;
      cdb_odds  = (phase == 1) ? 1 : (phase == 0 || phase == 4) ? 3 : 2;
      dispatch = '0;
      t = pick_tag(0);
      if (t >= 0 && rand_below(4) != 0) begin
         dispatch.valid = 1'b1;
         dispatch.fu_class = (phase == 3 && rand_below(4) != 0) ? rs_pkg::class_mul
                           : rs_pkg::fu_class_t'(rand_below(4));
         dispatch.rob_tag = rs_pkg::rob_tag_t'(t);
         dispatch.src_1   = rs_pkg::reg_idx_t'(src_base + rand_below(src_span));
         dispatch.src_2   = rs_pkg::reg_idx_t'(src_base + rand_below(src_span));
         dispatch.dest    = rs_pkg::reg_idx_t'(rand_below(8));
         dispatch.value_1 = source_value(dispatch.src_1);
         dispatch.value_2 = source_value(dispatch.src_2);
      end
      cdb = '0;
      t = pick_tag(1);
      if (t >= 0 && rand_below(4) < cdb_odds) begin
         cdb.valid = 1'b1;
         cdb.tag   = rs_pkg::rob_tag_t'(t);
         cdb.value = rs_pkg::word_t'($random(seed));
      end
      // retire odds follow the cdb odds
      retire = '0;
      t = pick_tag(2);
      if (t >= 0 && rand_below(4) < cdb_odds) begin
         retire.valid = 1'b1;
         retire.tag   = rs_pkg::rob_tag_t'(t);
         retire.dest  = tag_dest[t];
      end
      for (int i = 0; i < 5; i++) begin
         exec_busy[i] = (rand_below(8) < busy_odds);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // model of one rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic step_model();
      rs_pkg::station_vec_t grant_v;
      int                   target;
      rs_pkg::reg_idx_t     src [2];
      rs_pkg::word_t        dval [2];
      rs_pkg::operand_t     new_op [2];
      src[0]  = dispatch.src_1;
      src[1]  = dispatch.src_2;
      dval[0] = dispatch.value_1;
      dval[1] = dispatch.value_2;
      // ready stations go to idle units
      for (int i = 0; i < 5; i++) begin
         grant_v[i] = st_busy[i] && !st_op[i][0].waiting && !st_op[i][1].waiting
                    && !exec_busy[i];
      end
      // landing station, -1 for a full class
      target = -1;
      if (dispatch.valid) begin
         case (dispatch.fu_class)
            rs_pkg::class_alu:    target = st_busy[0] ? -1 : 0;
            rs_pkg::class_ldst:   target = st_busy[1] ? -1 : 1;
            rs_pkg::class_branch: target = st_busy[2] ? -1 : 2;
            default:              target = !st_busy[3] ? 3 : !st_busy[4] ? 4 : -1;
         endcase
      end
      // sources through the old map, cdb bypass in the same cycle
      for (int k = 0; k < 2; k++) begin
         new_op[k].waiting = 1'b0;
         new_op[k].tag     = map_tag[src[k]];
         new_op[k].value   = dval[k];
         if (map_pending[src[k]] && !map_ready[src[k]]) begin
            if (cdb.valid && cdb.tag == map_tag[src[k]]) begin
               new_op[k].value = cdb.value;
            end else begin
               new_op[k].waiting = 1'b1;
            end
         end
      end
      for (int i = 0; i < 5; i++) begin
         if (grant_v[i]) begin
            exp_data[i].fu_class = st_class[i];
            exp_data[i].rob_tag  = st_tag[i];
            exp_data[i].dest     = st_dest[i];
            exp_data[i].value_1  = st_op[i][0].value;
            exp_data[i].value_2  = st_op[i][1].value;
            st_busy[i] = 1'b0;
         end
         for (int k = 0; k < 2; k++) begin
            if (cdb.valid && st_op[i][k].waiting && st_op[i][k].tag == cdb.tag) begin
               st_op[i][k].waiting = 1'b0;
               st_op[i][k].value   = cdb.value;
            end
         end
      end
      exp_valid = grant_v;
      if (target >= 0) begin
         st_busy[target]  = 1'b1;
         st_class[target] = dispatch.fu_class;
         st_tag[target]   = dispatch.rob_tag;
         st_dest[target]  = dispatch.dest;
         st_op[target][0] = new_op[0];
         st_op[target][1] = new_op[1];
         tag_state[dispatch.rob_tag] = 1;
         tag_dest[dispatch.rob_tag]  = dispatch.dest;
      end
      // map table: cdb, then retire, then rename
      if (cdb.valid) begin
         for (int r = 0; r < 32; r++) begin
            if (map_pending[r] && map_tag[r] == cdb.tag) map_ready[r] = 1'b1;
         end
         tag_result[cdb.tag] = cdb.value;
         tag_state[cdb.tag]  = 2;
      end
      if (retire.valid) begin
         if (map_pending[retire.dest] && map_tag[retire.dest] == retire.tag) begin
            map_pending[retire.dest] = 1'b0;
            map_ready[retire.dest]   = 1'b0;
            arch_value[retire.dest]  = tag_result[retire.tag];
         end
         tag_state[retire.tag] = 0;
      end
      if (target >= 0 && dispatch.dest != 5'd0) begin
         map_pending[dispatch.dest] = 1'b1;
         map_ready[dispatch.dest]   = 1'b0;
         map_tag[dispatch.dest]     = dispatch.rob_tag;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      dispatch  = '0;
      cdb       = '0;
      retire    = '0;
      exec_busy = '0;
      st_busy   = '0;
      exp_valid = '0;
      for (int r = 0; r < 32; r++) begin
         map_pending[r] = 1'b0;
         map_ready[r]   = 1'b0;
         map_tag[r]     = '0;
         arch_value[r]  = rs_pkg::word_t'($random(seed));
      end
      for (int t = 0; t < 8; t++) begin
         tag_state[t] = 0;
      end
      @(negedge reset);
      check_outputs();
      // drive on the falling edge, check on the next one
      for (int cycle = 0; cycle < num_cycles; cycle++) begin
         current_test = phase_name(cycle / phase_cycles);
         drive_inputs(cycle / phase_cycles);
         step_model();
         @(negedge clock);
         check_outputs();
      end
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // all phases plus reset and a margin
   initial begin
      #(watchdog_ns);
      $display("timeout: the run did not complete within %0d ns", watchdog_ns);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock of 4 ns period; reset stays high for 3 rising edges and drops on a falling edge
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clock,
   output logic reset
);

   localparam int half_period_ns = 2;
   localparam int reset_cycles   = 3;

   initial begin
      clock = 1'b0;
      forever #(half_period_ns) clock = ~clock;
   end

   // release lines up with the testbench's drive edge
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// File: reservation_station.sv
// top of the station stage; dispatch source values must follow the rename rule
`timescale 1ns/100ps
`default_nettype none

module reservation_station (
   input  logic                    clock,
   input  logic                    reset,
   input  rs_pkg::dispatch_t       dispatch,
   input  rs_pkg::cdb_t            cdb,
   input  rs_pkg::retire_t         retire,
   input  rs_pkg::station_vec_t    exec_busy,
   output rs_pkg::station_vec_t    station_free,
   output rs_pkg::station_vec_t    issue_valid,
   output rs_pkg::issue_t          issue_data [rs_pkg::num_stations]
);

   ////////////////////////////////////////////////////////////////////////////
   // internal links
   ////////////////////////////////////////////////////////////////////////////

   rs_pkg::operand_t     operand_1;
   rs_pkg::operand_t     operand_2;
   logic                 accept;
   rs_pkg::entry_t       entries [rs_pkg::num_stations];
   rs_pkg::station_vec_t grant;

   // producer, renames and resolves sources
   rename_map u_rename_map (
      .clock        (clock),
      .reset        (reset),
      .dispatch     (dispatch),
      .cdb          (cdb),
      .retire       (retire),
      .station_free (station_free),
      .operand_1    (operand_1),
      .operand_2    (operand_2),
      .accept       (accept)
   );

   // buffer of waiting instructions
   station_array u_station_array (
      .clock        (clock),
      .reset        (reset),
      .dispatch     (dispatch),
      .accept       (accept),
      .operand_1    (operand_1),
      .operand_2    (operand_2),
      .cdb          (cdb),
      .grant        (grant),
      .entries      (entries),
      .station_free (station_free)
   );

   // consumer, grant frees the entry at the issuing edge
   issue_select u_issue_select (
      .clock       (clock),
      .reset       (reset),
      .entries     (entries),
      .exec_busy   (exec_busy),
      .grant       (grant),
      .issue_valid (issue_valid),
      .issue_data  (issue_data)
   );

endmodule

`default_nettype wire

// File: issue_select.sv
// issues every ready station whose unit is idle; no arbitration between stations
`timescale 1ns/100ps
`default_nettype none

module issue_select (
   input  logic                    clock,
   input  logic                    reset,
   input  rs_pkg::entry_t          entries [rs_pkg::num_stations],
   input  rs_pkg::station_vec_t    exec_busy,
   output rs_pkg::station_vec_t    grant,
   output rs_pkg::station_vec_t    issue_valid,
   output rs_pkg::issue_t          issue_data [rs_pkg::num_stations]
);

   // busy level seen at the issuing edge
   rs_pkg::station_vec_t exec_busy_q;

   ////////////////////////////////////////////////////////////////////////////
   // readiness
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < rs_pkg::num_stations; i++) begin
         grant[i] = entries[i].busy
                  && !entries[i].operand_1.waiting
                  && !entries[i].operand_2.waiting
                  && !exec_busy[i];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // issue registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         issue_valid <= '0;
      end else begin
         issue_valid <= grant;
      end
      exec_busy_q <= exec_busy;
   end

   // payload, only meaningful with issue_valid
   always_ff @(posedge clock) begin
      for (int i = 0; i < rs_pkg::num_stations; i++) begin
         if (grant[i]) begin
            issue_data[i].fu_class <= entries[i].fu_class;
            issue_data[i].rob_tag  <= entries[i].rob_tag;
            issue_data[i].dest     <= entries[i].dest;
            issue_data[i].value_1  <= entries[i].operand_1.value;
            issue_data[i].value_2  <= entries[i].operand_2.value;
         end
      end
   end

   no_issue_into_busy_unit: assert property (
      @(posedge clock) disable iff (reset) (issue_valid & exec_busy_q) == '0
   );

endmodule

`default_nettype wire

// File: station_array.sv
// five station entries, one per unit; mul prefers station mul0 over mul1
`timescale 1ns/100ps
`default_nettype none

module station_array (
   input  logic                    clock,
   input  logic                    reset,
   input  rs_pkg::dispatch_t       dispatch,
   input  logic                    accept,
   input  rs_pkg::operand_t        operand_1,
   input  rs_pkg::operand_t        operand_2,
   input  rs_pkg::cdb_t            cdb,
   input  rs_pkg::station_vec_t    grant,
   output rs_pkg::entry_t          entries [rs_pkg::num_stations],
   output rs_pkg::station_vec_t    station_free
);

   rs_pkg::station_vec_t target;
   rs_pkg::entry_t       new_entry;

   // wake a waiting operand on matching tag
   function automatic rs_pkg::operand_t capture(
      input rs_pkg::operand_t op,
      input rs_pkg::cdb_t     bus
   );
      rs_pkg::operand_t result;
      result = op;
      if (bus.valid && op.waiting && op.tag == bus.tag) begin
         result.waiting = 1'b0;
         result.value   = bus.value;
      end
      return result;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // station choice
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < rs_pkg::num_stations; i++) begin
         station_free[i] = !entries[i].busy;
      end
   end

   // one hot, only used together with accept
   always_comb begin
      target = '0;
      case (dispatch.fu_class)
         rs_pkg::class_alu:    target[rs_pkg::station_alu]    = 1'b1;
         rs_pkg::class_ldst:   target[rs_pkg::station_ldst]   = 1'b1;
         rs_pkg::class_branch: target[rs_pkg::station_branch] = 1'b1;
         default: begin
            // overflow into mul1 when mul0 is taken
            if (station_free[rs_pkg::station_mul0]) begin
               target[rs_pkg::station_mul0] = 1'b1;
            end else begin
               target[rs_pkg::station_mul1] = 1'b1;
            end
         end
      endcase
   end

   // operands arrive already resolved, cdb bypass included
   always_comb begin
      new_entry.busy      = 1'b1;
      new_entry.fu_class  = dispatch.fu_class;
      new_entry.rob_tag   = dispatch.rob_tag;
      new_entry.dest      = dispatch.dest;
      new_entry.operand_1 = operand_1;
      new_entry.operand_2 = operand_2;
   end

   ////////////////////////////////////////////////////////////////////////////
   // entry state
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      for (int i = 0; i < rs_pkg::num_stations; i++) begin
         if (reset) begin
            entries[i].busy <= 1'b0;
         end else if (accept && target[i]) begin
            // station is free here, so no grant or capture to merge
            entries[i] <= new_entry;
         end else begin
            if (grant[i]) begin
               entries[i].busy <= 1'b0;
            end
            // both operands may wait on the same tag
            entries[i].operand_1 <= capture(entries[i].operand_1, cdb);
            entries[i].operand_2 <= capture(entries[i].operand_2, cdb);
         end
      end
   end

   accept_hits_free_station: assert property (
      @(posedge clock) disable iff (reset) accept |-> (target & ~station_free) == '0
   );

   grant_hits_busy_station: assert property (
      @(posedge clock) disable iff (reset) (grant & station_free) == '0
   );

endmodule

`default_nettype wire

// File: rename_map.sv
// register map table; a dispatch is renamed only when its class has a free station
`timescale 1ns/100ps
`default_nettype none

module rename_map (
   input  logic                    clock,
   input  logic                    reset,
   input  rs_pkg::dispatch_t       dispatch,
   input  rs_pkg::cdb_t            cdb,
   input  rs_pkg::retire_t         retire,
   input  rs_pkg::station_vec_t    station_free,
   output rs_pkg::operand_t        operand_1,
   output rs_pkg::operand_t        operand_2,
   output logic                    accept
);

   // per register state
   logic [rs_pkg::num_regs-1:0] pending;
   logic [rs_pkg::num_regs-1:0] ready;
   rs_pkg::rob_tag_t            map_tag [rs_pkg::num_regs];

   logic class_free;

   // ready when unrenamed or value already in rob
   // else try the cdb this cycle, else wait on map tag
   function automatic rs_pkg::operand_t resolve(
      input logic             pending_bit,
      input logic             ready_bit,
      input rs_pkg::rob_tag_t tag,
      input rs_pkg::word_t    value,
      input rs_pkg::cdb_t     bus
   );
      rs_pkg::operand_t result;
      result.waiting = 1'b0;
      result.tag     = tag;
      result.value   = value;
      if (pending_bit && !ready_bit) begin
         if (bus.valid && bus.tag == tag) begin
            result.value = bus.value;
         end else begin
            result.waiting = 1'b1;
         end
      end
      return result;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // source lookup
   ////////////////////////////////////////////////////////////////////////////

   assign operand_1 = resolve(pending[dispatch.src_1], ready[dispatch.src_1],
                              map_tag[dispatch.src_1], dispatch.value_1, cdb);
   assign operand_2 = resolve(pending[dispatch.src_2], ready[dispatch.src_2],
                              map_tag[dispatch.src_2], dispatch.value_2, cdb);

   // station availability for the class
   always_comb begin
      case (dispatch.fu_class)
         rs_pkg::class_alu:    class_free = station_free[rs_pkg::station_alu];
         rs_pkg::class_ldst:   class_free = station_free[rs_pkg::station_ldst];
         rs_pkg::class_branch: class_free = station_free[rs_pkg::station_branch];
         default:              class_free = station_free[rs_pkg::station_mul0]
                                          | station_free[rs_pkg::station_mul1];
      endcase
   end

   assign accept = dispatch.valid && class_free;

   ////////////////////////////////////////////////////////////////////////////
   // table update
   ////////////////////////////////////////////////////////////////////////////

   // later writes win, so order is cdb, retire, rename
   always_ff @(posedge clock) begin
      if (reset) begin
         pending <= '0;
         ready   <= '0;
      end else begin
         if (cdb.valid) begin
            for (int r = 0; r < rs_pkg::num_regs; r++) begin
               if (pending[r] && map_tag[r] == cdb.tag) begin
                  ready[r] <= 1'b1;
               end
            end
         end
         // only if still named by the retiring tag
         if (retire.valid && pending[retire.dest] && map_tag[retire.dest] == retire.tag) begin
            pending[retire.dest] <= 1'b0;
            ready[retire.dest]   <= 1'b0;
         end
         if (accept && dispatch.dest != rs_pkg::zero_reg) begin
            pending[dispatch.dest] <= 1'b1;
            ready[dispatch.dest]   <= 1'b0;
         end
      end
   end

   // tag store, only read while pending
   always_ff @(posedge clock) begin
      if (accept && dispatch.dest != rs_pkg::zero_reg) begin
         map_tag[dispatch.dest] <= dispatch.rob_tag;
      end
   end

   zero_reg_never_pending: assert property (
      @(posedge clock) disable iff (reset) !pending[rs_pkg::zero_reg]
   );

endmodule

`default_nettype wire

// File: rs_pkg.sv
// shared types for the reservation stations; tags are 3 bits and must stay unique until retire
`default_nettype none

package rs_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int word_width   = 32;
   localparam int tag_width    = 3;
   localparam int reg_width    = 5;
   localparam int class_width  = 2;

   localparam int num_stations = 5;
   localparam int num_regs     = 32;

   // one station per unit, mul has two
   localparam int station_alu    = 0;
   localparam int station_ldst   = 1;
   localparam int station_branch = 2;
   localparam int station_mul0   = 3;
   localparam int station_mul1   = 4;

   ////////////////////////////////////////////////////////////////////////////
   // plain vector types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [word_width-1:0]   word_t;
   typedef logic [tag_width-1:0]    rob_tag_t;
   typedef logic [reg_width-1:0]    reg_idx_t;
   typedef logic [class_width-1:0]  fu_class_t;
   typedef logic [num_stations-1:0] station_vec_t;

   // never renamed, always reads the dispatch value
   localparam reg_idx_t zero_reg = '0;

   // unit class codes carried by a dispatch
   localparam fu_class_t class_alu    = 2'd0;
   localparam fu_class_t class_ldst   = 2'd1;
   localparam fu_class_t class_branch = 2'd2;
   localparam fu_class_t class_mul    = 2'd3;

   ////////////////////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////////////////////

   // source operand, value only meaningful once waiting is low
   typedef struct packed {
      logic     waiting;
      rob_tag_t tag;
      word_t    value;
   } operand_t;

   // result broadcast
   typedef struct packed {
      logic     valid;
      rob_tag_t tag;
      word_t    value;
   } cdb_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t dest;
      rob_tag_t tag;
   } retire_t;

   // values must be true for unrenamed or ready sources
   typedef struct packed {
      logic      valid;
      fu_class_t fu_class;
      rob_tag_t  rob_tag;
      reg_idx_t  src_1;
      reg_idx_t  src_2;
      reg_idx_t  dest;
      word_t     value_1;
      word_t     value_2;
   } dispatch_t;

   typedef struct packed {
      logic      busy;
      fu_class_t fu_class;
      rob_tag_t  rob_tag;
      reg_idx_t  dest;
      operand_t  operand_1;
      operand_t  operand_2;
   } entry_t;

   // payload handed to the unit
   typedef struct packed {
      fu_class_t fu_class;
      rob_tag_t  rob_tag;
      reg_idx_t  dest;
      word_t     value_1;
      word_t     value_2;
   } issue_t;

endpackage

`default_nettype wire
